// File: common/id_pkg.sv
package id_pkg;

    // ----------------------------------------
    // basic widths
    // ----------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // rv32i major opcodes.
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // funct7 tells add from sub and srl from sra.
    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

    localparam word_t EBREAK_WORD = 32'h0010_0073;

    // ----------------------------------------
    // instruction and operation kinds
    // ----------------------------------------
    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR, OP_LUI, OP_AUIPC, OP_EBREAK,
        OP_ILLEGAL
    } op_e;

    // N means the instruction carries no immediate.
    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_N
    } fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_SLTU   = 4'd3,
        ALU_AND    = 4'd4,
        ALU_OR     = 4'd5,
        ALU_XOR    = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // ----------------------------------------
    // packets
    // ----------------------------------------
    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_pkt_t;

    // control part of the decoded word.
    typedef struct packed {
        alu_op_e   alu_op;
        br_op_e    br_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      is_jump;
        logic      gpr_we;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      load_unsigned;
        logic      ebreak;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm;
        alu_op_e   alu_op;
        br_op_e    br_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      is_jump;
        logic      gpr_we;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      load_unsigned;
        logic      ebreak;
        logic      illegal;
    } dec_pkt_t;

endpackage

// File: decoder/ctrl_gen.sv
`timescale 1ns/1ns

module ctrl_gen (
    input  id_pkg::op_e   op,
    output id_pkg::fmt_e  fmt,
    output id_pkg::ctrl_t ctrl
);

    always_comb begin
        fmt  = id_pkg::FMT_N;
        ctrl = '0;

        case (op)
            // ----------------------------------------
            // alu, register and immediate forms
            // ----------------------------------------
            id_pkg::OP_ADD, id_pkg::OP_SUB, id_pkg::OP_SLL, id_pkg::OP_SLT,
            id_pkg::OP_SLTU, id_pkg::OP_XOR, id_pkg::OP_SRL, id_pkg::OP_SRA,
            id_pkg::OP_OR, id_pkg::OP_AND: begin
                fmt = id_pkg::FMT_R;
            end

            id_pkg::OP_ADDI, id_pkg::OP_SLTI, id_pkg::OP_SLTIU, id_pkg::OP_XORI,
            id_pkg::OP_ORI, id_pkg::OP_ANDI, id_pkg::OP_SLLI, id_pkg::OP_SRLI,
            id_pkg::OP_SRAI: begin
                fmt = id_pkg::FMT_I;
            end

            // ----------------------------------------
            // memory access
            // ----------------------------------------
            id_pkg::OP_LB, id_pkg::OP_LH, id_pkg::OP_LW,
            id_pkg::OP_LBU, id_pkg::OP_LHU: begin
                fmt           = id_pkg::FMT_I;
                ctrl.alu_op   = id_pkg::ALU_ADD;
                ctrl.mem_read = 1'b1;
            end

            id_pkg::OP_SB, id_pkg::OP_SH, id_pkg::OP_SW: begin
                fmt            = id_pkg::FMT_S;
                ctrl.alu_op    = id_pkg::ALU_ADD;
                ctrl.mem_write = 1'b1;
            end

            // ----------------------------------------
            // control flow
            // ----------------------------------------
            id_pkg::OP_BEQ, id_pkg::OP_BNE, id_pkg::OP_BLT,
            id_pkg::OP_BGE, id_pkg::OP_BLTU, id_pkg::OP_BGEU: begin
                fmt             = id_pkg::FMT_B;
                ctrl.src1_is_pc = 1'b1;
                ctrl.is_jump    = 1'b1;
            end

            id_pkg::OP_JAL: begin
                fmt             = id_pkg::FMT_J;
                ctrl.alu_op     = id_pkg::ALU_ADD;
                ctrl.src1_is_pc = 1'b1;
                ctrl.is_jump    = 1'b1;
            end

            id_pkg::OP_JALR: begin
                fmt          = id_pkg::FMT_I;
                ctrl.alu_op  = id_pkg::ALU_ADD;
                ctrl.is_jump = 1'b1;
            end

            id_pkg::OP_LUI: begin
                fmt         = id_pkg::FMT_U;
                ctrl.alu_op = id_pkg::ALU_PASS_B;
            end

            id_pkg::OP_AUIPC: begin
                fmt             = id_pkg::FMT_U;
                ctrl.alu_op     = id_pkg::ALU_ADD;
                ctrl.src1_is_pc = 1'b1;
            end

            id_pkg::OP_EBREAK: ctrl.ebreak = 1'b1;

            default: ctrl.illegal = 1'b1;
        endcase

        // alu operation of the arithmetic and logic group.
        case (op)
            id_pkg::OP_SUB:                    ctrl.alu_op = id_pkg::ALU_SUB;
            id_pkg::OP_SLT, id_pkg::OP_SLTI:   ctrl.alu_op = id_pkg::ALU_SLT;
            id_pkg::OP_SLTU, id_pkg::OP_SLTIU: ctrl.alu_op = id_pkg::ALU_SLTU;
            id_pkg::OP_AND, id_pkg::OP_ANDI:   ctrl.alu_op = id_pkg::ALU_AND;
            id_pkg::OP_OR, id_pkg::OP_ORI:     ctrl.alu_op = id_pkg::ALU_OR;
            id_pkg::OP_XOR, id_pkg::OP_XORI:   ctrl.alu_op = id_pkg::ALU_XOR;
            id_pkg::OP_SLL, id_pkg::OP_SLLI:   ctrl.alu_op = id_pkg::ALU_SLL;
            id_pkg::OP_SRL, id_pkg::OP_SRLI:   ctrl.alu_op = id_pkg::ALU_SRL;
            id_pkg::OP_SRA, id_pkg::OP_SRAI:   ctrl.alu_op = id_pkg::ALU_SRA;
            default: ;
        endcase

        // branch condition and load width.
        case (op)
            id_pkg::OP_BEQ:  ctrl.br_op = id_pkg::BR_EQ;
            id_pkg::OP_BNE:  ctrl.br_op = id_pkg::BR_NE;
            id_pkg::OP_BLT:  ctrl.br_op = id_pkg::BR_LT;
            id_pkg::OP_BGE:  ctrl.br_op = id_pkg::BR_GE;
            id_pkg::OP_BLTU: ctrl.br_op = id_pkg::BR_LTU;
            id_pkg::OP_BGEU: ctrl.br_op = id_pkg::BR_GEU;
            id_pkg::OP_LH, id_pkg::OP_SH: ctrl.mem_size = id_pkg::MEM_HALF;
            id_pkg::OP_LW, id_pkg::OP_SW: ctrl.mem_size = id_pkg::MEM_WORD;
            id_pkg::OP_LBU: ctrl.load_unsigned = 1'b1;
            id_pkg::OP_LHU: begin
                ctrl.mem_size      = id_pkg::MEM_HALF;
                ctrl.load_unsigned = 1'b1;
            end
            default: ;
        endcase

        // operand select and writeback follow from the format.
        ctrl.src2_is_imm = (fmt != id_pkg::FMT_R) && (fmt != id_pkg::FMT_N);
        ctrl.gpr_we      = fmt inside {id_pkg::FMT_R, id_pkg::FMT_I,
                                       id_pkg::FMT_U, id_pkg::FMT_J};
    end

endmodule

// File: decoder/imm_gen.sv
`timescale 1ns/1ns

module imm_gen (
    input  id_pkg::word_t inst,
    input  id_pkg::fmt_e  fmt,
    output id_pkg::word_t imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (fmt)
            id_pkg::FMT_I: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            // store offset is split around rd.
            id_pkg::FMT_S: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            id_pkg::FMT_B: begin
                imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            id_pkg::FMT_U: begin
                imm = {inst[31:12], 12'b0};
            end
            id_pkg::FMT_J: begin
                imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            // r and n formats carry no immediate.
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: decoder/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  id_pkg::word_t inst,
    output id_pkg::op_e   op
);

    id_pkg::opcode_t opcode;
    id_pkg::funct3_t funct3;
    logic [6:0]      funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op = id_pkg::OP_ILLEGAL;
        case (opcode)
            // ----------------------------------------
            // register-register alu
            // ----------------------------------------
            id_pkg::OPC_OP: begin
                if (funct7 == id_pkg::F7_BASE) begin
                    case (funct3)
                        3'b000: op = id_pkg::OP_ADD;
                        3'b001: op = id_pkg::OP_SLL;
                        3'b010: op = id_pkg::OP_SLT;
                        3'b011: op = id_pkg::OP_SLTU;
                        3'b100: op = id_pkg::OP_XOR;
                        3'b101: op = id_pkg::OP_SRL;
                        3'b110: op = id_pkg::OP_OR;
                        3'b111: op = id_pkg::OP_AND;
                        default: op = id_pkg::OP_ILLEGAL;
                    endcase
                end else if (funct7 == id_pkg::F7_ALT) begin
                    // only sub and sra use the alternate funct7.
                    case (funct3)
                        3'b000: op = id_pkg::OP_SUB;
                        3'b101: op = id_pkg::OP_SRA;
                        default: op = id_pkg::OP_ILLEGAL;
                    endcase
                end
            end

            // ----------------------------------------
            // register-immediate alu
            // ----------------------------------------
            id_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b000: op = id_pkg::OP_ADDI;
                    3'b010: op = id_pkg::OP_SLTI;
                    3'b011: op = id_pkg::OP_SLTIU;
                    3'b100: op = id_pkg::OP_XORI;
                    3'b110: op = id_pkg::OP_ORI;
                    3'b111: op = id_pkg::OP_ANDI;
                    3'b001: begin
                        if (funct7 == id_pkg::F7_BASE) begin
                            op = id_pkg::OP_SLLI;
                        end
                    end
                    3'b101: begin
                        if (funct7 == id_pkg::F7_BASE) begin
                            op = id_pkg::OP_SRLI;
                        end else if (funct7 == id_pkg::F7_ALT) begin
                            op = id_pkg::OP_SRAI;
                        end
                    end
                    default: op = id_pkg::OP_ILLEGAL;
                endcase
            end

            id_pkg::OPC_LOAD: begin
                case (funct3)
                    3'b000: op = id_pkg::OP_LB;
                    3'b001: op = id_pkg::OP_LH;
                    3'b010: op = id_pkg::OP_LW;
                    3'b100: op = id_pkg::OP_LBU;
                    3'b101: op = id_pkg::OP_LHU;
                    default: op = id_pkg::OP_ILLEGAL;
                endcase
            end

            id_pkg::OPC_STORE: begin
                case (funct3)
                    3'b000: op = id_pkg::OP_SB;
                    3'b001: op = id_pkg::OP_SH;
                    3'b010: op = id_pkg::OP_SW;
                    default: op = id_pkg::OP_ILLEGAL;
                endcase
            end

            id_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000: op = id_pkg::OP_BEQ;
                    3'b001: op = id_pkg::OP_BNE;
                    3'b100: op = id_pkg::OP_BLT;
                    3'b101: op = id_pkg::OP_BGE;
                    3'b110: op = id_pkg::OP_BLTU;
                    3'b111: op = id_pkg::OP_BGEU;
                    default: op = id_pkg::OP_ILLEGAL;
                endcase
            end

            id_pkg::OPC_JAL:   op = id_pkg::OP_JAL;
            id_pkg::OPC_LUI:   op = id_pkg::OP_LUI;
            id_pkg::OPC_AUIPC: op = id_pkg::OP_AUIPC;

            id_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    op = id_pkg::OP_JALR;
                end
            end

            // ecall, mret and csr accesses fall through as illegal.
            id_pkg::OPC_SYSTEM: begin
                if (inst == id_pkg::EBREAK_WORD) begin
                    op = id_pkg::OP_EBREAK;
                end
            end

            default: op = id_pkg::OP_ILLEGAL;
        endcase
    end

endmodule

// File: rtl/id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  id_pkg::fetch_pkt_t in_pkt,
    output logic               out_valid,
    input  logic               out_ready,
    output id_pkg::dec_pkt_t   out_pkt
);

    // first slot holds the fetched word.
    logic               a_valid;
    id_pkg::fetch_pkt_t a_pkt;

    logic               b_open;
    logic               a_adv;

    id_pkg::op_e        op;
    id_pkg::fmt_e       fmt;
    id_pkg::ctrl_t      ctrl;
    id_pkg::word_t      imm;
    id_pkg::dec_pkt_t   dec_next;

    // ----------------------------------------
    // handshake
    // ----------------------------------------
    // output slot can take a word when empty or being drained.
    assign b_open   = ~out_valid | out_ready;
    assign a_adv    = a_valid & b_open;
    assign in_ready = ~a_valid | b_open;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_valid   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (in_ready) begin
                a_valid <= in_valid;
            end
            if (b_open) begin
                out_valid <= a_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            a_pkt <= in_pkt;
        end
        if (a_adv) begin
            out_pkt <= dec_next;
        end
    end

    // ----------------------------------------
    // decode
    // ----------------------------------------
    inst_decoder i_inst_decoder (
        .inst (a_pkt.inst),
        .op   (op)
    );

    ctrl_gen i_ctrl_gen (
        .op   (op),
        .fmt  (fmt),
        .ctrl (ctrl)
    );

    imm_gen i_imm_gen (
        .inst (a_pkt.inst),
        .fmt  (fmt),
        .imm  (imm)
    );

    always_comb begin
        dec_next.pc            = a_pkt.pc;
        dec_next.rd            = a_pkt.inst[11:7];
        dec_next.rs1           = a_pkt.inst[19:15];
        dec_next.rs2           = a_pkt.inst[24:20];
        dec_next.imm           = imm;
        dec_next.alu_op        = ctrl.alu_op;
        dec_next.br_op         = ctrl.br_op;
        dec_next.src1_is_pc    = ctrl.src1_is_pc;
        dec_next.src2_is_imm   = ctrl.src2_is_imm;
        dec_next.is_jump       = ctrl.is_jump;
        dec_next.gpr_we        = ctrl.gpr_we;
        dec_next.mem_read      = ctrl.mem_read;
        dec_next.mem_write     = ctrl.mem_write;
        dec_next.mem_size      = ctrl.mem_size;
        dec_next.load_unsigned = ctrl.load_unsigned;
        dec_next.ebreak        = ctrl.ebreak;
        dec_next.illegal       = ctrl.illegal;
    end

endmodule

// File: sources.f
common/id_pkg.sv
decoder/inst_decoder.sv
decoder/ctrl_gen.sv
decoder/imm_gen.sv
rtl/id_stage.sv
verification/tb_id_stage.sv

// File: verification/id_tests.txt
# hex columns: pc inst rd rs1 rs2 imm alu_op br_op src1_is_pc src2_is_imm is_jump gpr_we
# mem_read mem_write mem_size load_unsigned ebreak illegal
00001000 002081b3 03 01 02 00000000 0 0 0 0 0 1 0 0 0 0 0 0
00001004 407302b3 05 06 07 00000000 1 0 0 0 0 1 0 0 0 0 0 0
00001008 00c59533 0a 0b 0c 00000000 7 0 0 0 0 1 0 0 0 0 0 0
0000100c 0062b233 04 05 06 00000000 3 0 0 0 0 1 0 0 0 0 0 0
00001010 00f756b3 0d 0e 0f 00000000 8 0 0 0 0 1 0 0 0 0 0 0
00001014 4128d833 10 11 12 00000000 9 0 0 0 0 1 0 0 0 0 0 0
00001018 018bfb33 16 17 18 00000000 4 0 0 0 0 1 0 0 0 0 0 0
0000101c fff10093 01 02 1f ffffffff 0 0 0 1 0 1 0 0 0 0 0 0
00001020 06422193 03 04 04 00000064 2 0 0 1 0 1 0 0 0 0 0 0
00001024 80033293 05 06 00 fffff800 3 0 0 1 0 1 0 0 0 0 0 0
00001028 00571693 0d 0e 05 00000005 7 0 0 1 0 1 0 0 0 0 0 0
0000102c 40395893 11 12 03 00000403 9 0 0 1 0 1 0 0 0 0 0 0
00001030 ffc10083 01 02 1c fffffffc 0 0 0 1 0 1 1 0 0 0 0 0
00001034 00821183 03 04 08 00000008 0 0 0 1 0 1 1 0 1 0 0 0
00001038 01032283 05 06 10 00000010 0 0 0 1 0 1 1 0 2 0 0 0
0000103c 00144383 07 08 01 00000001 0 0 0 1 0 1 1 0 0 1 0 0
00001040 ffe55483 09 0a 1e fffffffe 0 0 0 1 0 1 1 0 1 1 0 0
00001044 005301a3 03 06 05 00000003 0 0 0 1 0 0 0 1 0 0 0 0
00001048 fe741d23 1a 08 07 fffffffa 0 0 0 1 0 0 0 1 1 0 0 0
0000104c 12952223 04 0a 09 00000124 0 0 0 1 0 0 0 1 2 0 0 0
00001050 00208463 08 01 02 00000008 0 1 1 1 1 0 0 0 0 0 0 0
00001054 fe4198e3 11 03 04 fffffff0 0 2 1 1 1 0 0 0 0 0 0 0
00001058 0062c0e3 01 05 06 00000800 0 3 1 1 1 0 0 0 0 0 0 0
0000105c 8083d063 00 07 08 fffff000 0 4 1 1 1 0 0 0 0 0 0 0
00001060 7ea4ef63 1e 09 0a 000007fe 0 5 1 1 1 0 0 0 0 0 0 0
00001064 00c5f663 0c 0b 0c 0000000c 0 6 1 1 1 0 0 0 0 0 0 0
00001068 fffff06f 00 1f 1f fffffffe 0 0 1 1 1 1 0 0 0 0 0 0
0000106c 344122ef 05 02 04 00012344 0 0 1 1 1 1 0 0 0 0 0 0
00001070 004280e7 01 05 04 00000004 0 0 0 1 1 1 0 0 0 0 0 0
00001074 87654537 0a 0a 16 87654000 a 0 0 1 0 1 0 0 0 0 0 0
00001078 00001197 03 00 00 00001000 0 0 1 1 0 1 0 0 0 0 0 0
0000107c 00100073 00 00 01 00000000 0 0 0 0 0 0 0 0 0 0 1 0
00001080 00000073 00 00 00 00000000 0 0 0 0 0 0 0 0 0 0 0 1
00001084 ffffffff 1f 1f 1f 00000000 0 0 0 0 0 0 0 0 0 0 0 1
00001088 418bfb33 16 17 18 00000000 0 0 0 0 0 0 0 0 0 0 0 1
0000108c 40571693 0d 0e 05 00000000 0 0 0 0 0 0 0 0 0 0 0 1

// File: verification/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_COLS   = 18;

    logic               clk = 1'b0;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    id_pkg::fetch_pkt_t in_pkt;
    logic               out_valid;
    logic               out_ready;
    id_pkg::dec_pkt_t   out_pkt;

    id_pkg::fetch_pkt_t stim[$];
    id_pkg::dec_pkt_t   expected[$];

    int                 num_tests;
    int                 num_checked;
    int                 errors;
    integer             seed_in;
    integer             seed_out;
    logic               loaded;
    logic               stalled;
    id_pkg::dec_pkt_t   held_pkt;

    id_stage i_id_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // test file
    // ----------------------------------------
    task automatic load_tests();
        integer             fd;
        integer             cnt;
        logic [8*160-1:0]   line;
        logic [31:0]        col [0:NUM_COLS-1];
        id_pkg::fetch_pkt_t f;
        id_pkg::dec_pkt_t   d;
        fd = $fopen("verification/id_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/id_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                // comment and blank lines give no match.
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              col[0], col[1], col[2], col[3], col[4], col[5],
                              col[6], col[7], col[8], col[9], col[10], col[11],
                              col[12], col[13], col[14], col[15], col[16], col[17]);
                if (cnt == NUM_COLS) begin
                    f.pc            = col[0];
                    f.inst          = col[1];
                    d.pc            = col[0];
                    d.rd            = col[2][4:0];
                    d.rs1           = col[3][4:0];
                    d.rs2           = col[4][4:0];
                    d.imm           = col[5];
                    d.alu_op        = id_pkg::alu_op_e'(col[6][3:0]);
                    d.br_op         = id_pkg::br_op_e'(col[7][2:0]);
                    d.src1_is_pc    = col[8][0];
                    d.src2_is_imm   = col[9][0];
                    d.is_jump       = col[10][0];
                    d.gpr_we        = col[11][0];
                    d.mem_read      = col[12][0];
                    d.mem_write     = col[13][0];
                    d.mem_size      = id_pkg::mem_size_e'(col[14][1:0]);
                    d.load_unsigned = col[15][0];
                    d.ebreak        = col[16][0];
                    d.illegal       = col[17][0];
                    stim.push_back(f);
                    expected.push_back(d);
                end
            end
        end
        $fclose(fd);
        if (expected.size() == 0) begin
            $display("the test file holds no test lines");
            errors++;
        end
    endtask

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("Mismatch at %0t ns: out_pkt.%s expected %h, got %h",
                     $time, name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic compare_packet(input id_pkg::dec_pkt_t exp_pkt);
        check_field("pc", exp_pkt.pc, out_pkt.pc);
        check_field("rd", exp_pkt.rd, out_pkt.rd);
        check_field("rs1", exp_pkt.rs1, out_pkt.rs1);
        check_field("rs2", exp_pkt.rs2, out_pkt.rs2);
        check_field("imm", exp_pkt.imm, out_pkt.imm);
        check_field("alu_op", exp_pkt.alu_op, out_pkt.alu_op);
        check_field("br_op", exp_pkt.br_op, out_pkt.br_op);
        check_field("src1_is_pc", exp_pkt.src1_is_pc, out_pkt.src1_is_pc);
        check_field("src2_is_imm", exp_pkt.src2_is_imm, out_pkt.src2_is_imm);
        check_field("is_jump", exp_pkt.is_jump, out_pkt.is_jump);
        check_field("gpr_we", exp_pkt.gpr_we, out_pkt.gpr_we);
        check_field("mem_read", exp_pkt.mem_read, out_pkt.mem_read);
        check_field("mem_write", exp_pkt.mem_write, out_pkt.mem_write);
        check_field("mem_size", exp_pkt.mem_size, out_pkt.mem_size);
        check_field("load_unsigned", exp_pkt.load_unsigned, out_pkt.load_unsigned);
        check_field("ebreak", exp_pkt.ebreak, out_pkt.ebreak);
        check_field("illegal", exp_pkt.illegal, out_pkt.illegal);
    endtask

    task automatic check_idle(input string when_text);
        assert (out_valid === 1'b0) else begin
            $display("Mismatch at %0t ns %s: out_valid expected 0, got %b",
                     $time, when_text, out_valid);
            errors++;
        end
        assert (in_ready === 1'b1) else begin
            $display("Mismatch at %0t ns %s: in_ready expected 1, got %b",
                     $time, when_text, in_ready);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            check_idle("during reset");
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            stalled <= 1'b0;
        end else begin
            // a stalled packet must still be there on the next edge.
            if (stalled) begin
                assert (out_valid === 1'b1) else begin
                    $display("Mismatch at %0t ns: out_valid expected 1 while stalled, got %b",
                             $time, out_valid);
                    errors++;
                end
                assert (out_pkt === held_pkt) else begin
                    $display("Mismatch at %0t ns: out_pkt expected %h while stalled, got %h",
                             $time, held_pkt, out_pkt);
                    errors++;
                end
            end
            if (out_valid && out_ready) begin
                assert (expected.size() > 0) else begin
                    $display("extra output packet at %0t ns after all tests", $time);
                    errors++;
                end
                if (expected.size() > 0) begin
                    compare_packet(expected.pop_front());
                    num_checked++;
                end
            end
            stalled  <= out_valid && !out_ready;
            held_pkt <= out_pkt;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic drive_inputs();
        int sent;
        sent = 0;
        while (sent < num_tests) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                sent++;
            end
            // a word on offer stays until it is taken.
            if (!in_valid || in_ready) begin
                if (sent < num_tests && ($random(seed_in) & 3) != 0) begin
                    in_valid <= 1'b1;
                    in_pkt   <= stim[sent];
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= ($random(seed_out) & 1) != 0;
        end
    end

    task finish_run();
        $display("errors: %0d, tests checked: %0d of %0d", errors, num_checked, num_tests);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_pkt      = '0;
        out_ready   = 1'b0;
        seed_in     = 29541;
        seed_out    = 29541;
        errors      = 0;
        num_checked = 0;
        loaded      = 1'b0;
        stalled     = 1'b0;
        held_pkt    = '0;
        load_tests();
        num_tests = expected.size();
        loaded    = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_idle("on the first edge after reset");
        drive_inputs();
        wait (num_checked == num_tests);
        repeat (4) @(posedge clk);
        finish_run();
    end

    // watchdog allows 30 cycles per test on top of reset.
    initial begin
        wait (loaded);
        #((16 + num_tests * 30) * CLK_PERIOD);
        $display("timeout: only %0d of %0d tests came out in time", num_checked, num_tests);
        errors++;
        finish_run();
    end

endmodule
